//--- sources.f
rtl/fp32_pkg.sv
rtl/fpu_op_pkg.sv
rtl/fpu_op_decoder.sv
rtl/fp32_classifier.sv
rtl/fp32_noncomp_unit.sv
rtl/fpu_result_pipe.sv
rtl/fpu_noncomp_top.sv
dv/tb_fpu_noncomp.sv

//--- dv/tb_fpu_noncomp.sv
`timescale 1ns/1ps

module tb_fpu_noncomp;

  localparam int LATENCY      = 2;
  localparam int TAG_W        = 3;
  localparam int RESET_CYCLES = 10;
  localparam int N_OPS        = 93;  // ops issued over all tests
  localparam int TIMEOUT_CYCLES = N_OPS + LATENCY + 50;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_valid_i;
  fpu_op_pkg::fpu_op_e  i_op_i;
  logic [TAG_W-1:0]     i_tag_i;
  fp32_pkg::fp32_t      i_rs1_i;
  fp32_pkg::fp32_t      i_rs2_i;
  logic                 o_valid_o;
  logic [31:0]          o_result_o;
  fp32_pkg::fflags_t    o_fflags_o;
  logic [TAG_W-1:0]     o_tag_o;

  fp32_pkg::fpu_resp_t  exp_resp_q [$];
  logic [TAG_W-1:0]     exp_tag_q  [$];
  int                   exp_cyc_q  [$];

  int               seed     = 32'h0b3dae04;
  int               cyc      = 0;
  logic [TAG_W-1:0] next_tag = '0;

  fpu_noncomp_top #(
    .LATENCY (LATENCY),
    .TAG_W   (TAG_W)
  ) dut_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid_i  (i_valid_i),
    .i_op_i     (i_op_i),
    .i_tag_i    (i_tag_i),
    .i_rs1_i    (i_rs1_i),
    .i_rs2_i    (i_rs2_i),
    .o_valid_o  (o_valid_o),
    .o_result_o (o_result_o),
    .o_fflags_o (o_fflags_o),
    .o_tag_o    (o_tag_o)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic is_nan(logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic logic is_zero(logic [31:0] x);
    return x[30:0] == 31'd0;
  endfunction

  // numeric order of two non-NaN values, zeros equal
  function automatic logic less_than(logic [31:0] a, logic [31:0] b);
    if (is_zero(a) && is_zero(b)) return 1'b0;
    if (a[31] != b[31]) return a[31];
    if (a[31]) return a[30:0] > b[30:0];
    return a[30:0] < b[30:0];
  endfunction

  function automatic logic [31:0] pick_minmax(logic [31:0] a, logic [31:0] b, logic is_max);
    logic a_below;
    if (is_nan(a) && is_nan(b)) return 32'h7fc00000;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    if (is_zero(a) && is_zero(b)) a_below = a[31];  // -0 below +0
    else a_below = less_than(a, b);
    if (is_max) return a_below ? b : a;
    return a_below ? a : b;
  endfunction

  function automatic logic [31:0] class_mask(logic [31:0] x);
    int idx;
    if (is_nan(x)) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hff) idx = x[31] ? 0 : 7;
    else if (is_zero(x)) idx = x[31] ? 3 : 4;
    else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 32'd1 << idx;
  endfunction

  function automatic fp32_pkg::fpu_resp_t expected_resp(fpu_op_pkg::fpu_op_e op,
                                                        logic [31:0] a, logic [31:0] b);
    fp32_pkg::fpu_resp_t r;
    logic any_nan;
    logic any_snan;
    logic same;
    r        = '0;
    any_nan  = is_nan(a) || is_nan(b);
    any_snan = is_snan(a) || is_snan(b);
    same     = (a == b) || (is_zero(a) && is_zero(b));
    case (op)
      fpu_op_pkg::OP_FSGNJ:  r.result = {b[31], a[30:0]};
      fpu_op_pkg::OP_FSGNJN: r.result = {~b[31], a[30:0]};
      fpu_op_pkg::OP_FSGNJX: r.result = {a[31] ^ b[31], a[30:0]};
      fpu_op_pkg::OP_FMIN, fpu_op_pkg::OP_FMAX: begin
        r.result    = pick_minmax(a, b, op == fpu_op_pkg::OP_FMAX);
        r.fflags.nv = any_snan;
      end
      fpu_op_pkg::OP_FEQ: begin
        r.result[0] = !any_nan && same;
        r.fflags.nv = any_snan;  // quiet compare
      end
      fpu_op_pkg::OP_FLT: begin
        r.result[0] = !any_nan && less_than(a, b);
        r.fflags.nv = any_nan;
      end
      fpu_op_pkg::OP_FLE: begin
        r.result[0] = !any_nan && (less_than(a, b) || same);
        r.fflags.nv = any_nan;
      end
      default: r.result = class_mask(a);
    endcase
    return r;
  endfunction

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_resp(fp32_pkg::fpu_resp_t exp_v, fp32_pkg::fpu_resp_t act_v);
    if (exp_v !== act_v) begin
      stop_on_error(
        $sformatf("CHECK FAILED time=%0t signal={o_result_o,o_fflags_o} expected=%h actual=%h",
                  $time, exp_v, act_v));
    end
  endtask

  task automatic check_tag(logic [TAG_W-1:0] exp_v, logic [TAG_W-1:0] act_v);
    if (exp_v !== act_v) begin
      stop_on_error($sformatf("CHECK FAILED time=%0t signal=o_tag_o expected=%h actual=%h",
                              $time, exp_v, act_v));
    end
  endtask

  task automatic check_valid(logic exp_v, logic act_v);
    if (exp_v !== act_v) begin
      stop_on_error($sformatf("CHECK FAILED time=%0t signal=o_valid_o expected=%b actual=%b",
                              $time, exp_v, act_v));
    end
  endtask

  // cycle count, also the timeout
  always @(posedge i_clk) begin
    cyc++;
    if (cyc > TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // outputs are stable at the falling edge
  always @(negedge i_clk) begin
    fp32_pkg::fpu_resp_t act;
    if (i_reset_n && o_valid_o === 1'b1) begin
      if (exp_resp_q.size() == 0) begin
        stop_on_error($sformatf("output at time %0t with no op in flight", $time));
      end else begin
        act.result = o_result_o;
        act.fflags = o_fflags_o;
        check_resp(exp_resp_q.pop_front(), act);
        check_tag(exp_tag_q.pop_front(), o_tag_o);
        if (exp_cyc_q[0] != cyc) begin
          stop_on_error($sformatf("output came in cycle %0d but was due in cycle %0d",
                                  cyc, exp_cyc_q[0]));
        end
        void'(exp_cyc_q.pop_front());
      end
    end
  end

  // called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic issue_op(fpu_op_pkg::fpu_op_e op, logic [31:0] a, logic [31:0] b);
    i_valid_i = 1'b1;
    i_op_i    = op;
    i_tag_i   = next_tag;
    i_rs1_i   = a;
    i_rs2_i   = b;
    if (op <= 4'd8) begin  // 9..15 give no output
      exp_resp_q.push_back(expected_resp(op, a, b));
      exp_tag_q.push_back(next_tag);
      exp_cyc_q.push_back(cyc + LATENCY);
    end
    next_tag++;
    @(posedge i_clk);
    #1;
  endtask

  task automatic drain;
    i_valid_i = 1'b0;
    while (exp_resp_q.size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic single_op_latency;
    repeat (4) begin
      @(negedge i_clk);
      check_valid(1'b0, o_valid_o);
    end
    @(posedge i_clk);
    #1;
    issue_op(fpu_op_pkg::OP_FSGNJX, 32'hc0490fdb, 32'hbf800000);
    i_valid_i = 1'b0;
    repeat (LATENCY - 1) begin
      @(negedge i_clk);
      check_valid(1'b0, o_valid_o);
    end
    @(negedge i_clk);
    check_valid(1'b1, o_valid_o);  // monitor checks data here
    @(posedge i_clk);
    #1;
  endtask

  task automatic sign_injection;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      issue_op(fpu_op_pkg::OP_FSGNJ, a, b);
      issue_op(fpu_op_pkg::OP_FSGNJN, a, b);
      issue_op(fpu_op_pkg::OP_FSGNJX, a, b);
    end
    drain();
  endtask

  task automatic min_max_cases;
    logic [31:0] pa [6] = '{32'h00000000, 32'h80000000, 32'h7fc00000,
                            32'hc0400000, 32'h7fc00000, 32'h7f800001};
    logic [31:0] pb [6] = '{32'h80000000, 32'h00000000, 32'h40400000,
                            32'h7fc00000, 32'h7f800001, 32'h3f800000};
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 6; i++) begin
      issue_op(fpu_op_pkg::OP_FMIN, pa[i], pb[i]);
      issue_op(fpu_op_pkg::OP_FMAX, pa[i], pb[i]);
    end
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      issue_op(fpu_op_pkg::OP_FMIN, a, b);
      issue_op(fpu_op_pkg::OP_FMAX, a, b);
    end
    drain();
  endtask

  task automatic compare_cases;
    logic [31:0] pa [6] = '{32'h3f800000, 32'h3f800000, 32'hc0000000,
                            32'h00000000, 32'h7fc00000, 32'h3f800000};
    logic [31:0] pb [6] = '{32'h3f800000, 32'h40000000, 32'hbf800000,
                            32'h80000000, 32'h3f800000, 32'h7f800001};
    for (int i = 0; i < 6; i++) begin
      issue_op(fpu_op_pkg::OP_FEQ, pa[i], pb[i]);
      issue_op(fpu_op_pkg::OP_FLT, pa[i], pb[i]);
      issue_op(fpu_op_pkg::OP_FLE, pa[i], pb[i]);
    end
    drain();
  endtask

  task automatic classify_each_class;
    // one value per class, mask bit 0 upwards
    logic [31:0] vals [10] = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000,
                               32'h00000000, 32'h00000001, 32'h3f800000, 32'h7f800000,
                               32'h7f800001, 32'h7fc00000};
    for (int i = 0; i < 10; i++) begin
      issue_op(fpu_op_pkg::OP_FCLASS, vals[i], $random(seed));
    end
    drain();
  endtask

  task automatic back_to_back_mix;
    logic [3:0] codes [12] = '{4'd0, 4'd5, 4'd9, 4'd4, 4'd8, 4'd15,
                               4'd6, 4'd1, 4'd12, 4'd3, 4'd7, 4'd2};
    for (int i = 0; i < 12; i++) begin
      issue_op(fpu_op_pkg::fpu_op_e'(codes[i]), $random(seed), $random(seed));
    end
    drain();
  endtask

  initial begin
    i_reset_n = 1'b0;
    i_valid_i = 1'b0;
    i_op_i    = fpu_op_pkg::OP_FSGNJ;
    i_tag_i   = '0;
    i_rs1_i   = '0;
    i_rs2_i   = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    single_op_latency();
    sign_injection();
    min_max_cases();
    compare_cases();
    classify_each_class();
    back_to_back_mix();
    repeat (LATENCY + 2) @(posedge i_clk);  // catch stray outputs
    if (exp_resp_q.size() != 0) begin
      stop_on_error($sformatf("%0d expected outputs never arrived", exp_resp_q.size()));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- rtl/fpu_noncomp_top.sv
`timescale 1ns/1ps

module fpu_noncomp_top #(
  parameter int LATENCY = 2,
  parameter int TAG_W   = 3
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_valid_i,
  input  fpu_op_pkg::fpu_op_e  i_op_i,
  input  logic [TAG_W-1:0]     i_tag_i,
  input  fp32_pkg::fp32_t      i_rs1_i,
  input  fp32_pkg::fp32_t      i_rs2_i,
  output logic                 o_valid_o,
  output logic [31:0]          o_result_o,
  output fp32_pkg::fflags_t    o_fflags_o,
  output logic [TAG_W-1:0]     o_tag_o
);

  fpu_op_pkg::fpu_dec_t  w_dec;
  logic                  w_launch;
  fp32_pkg::fpu_resp_t   w_resp;
  fp32_pkg::fpu_resp_t   w_out_resp;

  fpu_op_decoder u_dec (
    .i_valid_i  (i_valid_i),
    .i_op_i     (i_op_i),
    .o_dec_o    (w_dec),
    .o_launch_o (w_launch)
  );

  fp32_noncomp_unit u_noncomp (
    .i_dec_i  (w_dec),
    .i_rs1_i  (i_rs1_i),
    .i_rs2_i  (i_rs2_i),
    .o_resp_o (w_resp)
  );

  fpu_result_pipe #(
    .LATENCY (LATENCY),
    .TAG_W   (TAG_W)
  ) u_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid_i (w_launch),
    .i_resp_i  (w_resp),
    .i_tag_i   (i_tag_i),
    .o_valid_o (o_valid_o),
    .o_resp_o  (w_out_resp),
    .o_tag_o   (o_tag_o)
  );

  assign o_result_o = w_out_resp.result;
  assign o_fflags_o = w_out_resp.fflags;

endmodule

//--- rtl/fpu_result_pipe.sv
`timescale 1ns/1ps

module fpu_result_pipe #(
  parameter int LATENCY = 2,
  parameter int TAG_W   = 3
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_valid_i,
  input  fp32_pkg::fpu_resp_t  i_resp_i,
  input  logic [TAG_W-1:0]     i_tag_i,
  output logic                 o_valid_o,
  output fp32_pkg::fpu_resp_t  o_resp_o,
  output logic [TAG_W-1:0]     o_tag_o
);

  logic [LATENCY-1:0]   r_valid;
  fp32_pkg::fpu_resp_t  r_resp [LATENCY];
  logic [TAG_W-1:0]     r_tag  [LATENCY];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      r_valid[0] <= i_valid_i;
      for (int i = 1; i < LATENCY; i++) begin
        r_valid[i] <= r_valid[i-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid_i) begin
      r_resp[0] <= i_resp_i;
      r_tag[0]  <= i_tag_i;
    end
    for (int i = 1; i < LATENCY; i++) begin
      if (r_valid[i-1]) begin  // move only live entries
        r_resp[i] <= r_resp[i-1];
        r_tag[i]  <= r_tag[i-1];
      end
    end
  end

  assign o_valid_o = r_valid[LATENCY-1];
  assign o_resp_o  = r_resp[LATENCY-1];
  assign o_tag_o   = r_tag[LATENCY-1];

  a_valid_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(o_valid_o))
    else $error("o_valid_o unknown after reset");

endmodule

//--- rtl/fp32_noncomp_unit.sv
`timescale 1ns/1ps

module fp32_noncomp_unit (
  input  fpu_op_pkg::fpu_dec_t  i_dec_i,
  input  fp32_pkg::fp32_t       i_rs1_i,
  input  fp32_pkg::fp32_t       i_rs2_i,
  output fp32_pkg::fpu_resp_t   o_resp_o
);

  fp32_pkg::fp32_class_t w_cls1;
  fp32_pkg::fp32_class_t w_cls2;

  logic                          w_sgn;
  logic [31:0]                   w_sgnj_res;
  logic                          w_mag_lt;
  logic                          w_bits_eq;
  logic                          w_both_zero;
  logic                          w_any_nan;
  logic                          w_any_snan;
  logic                          w_lt_ord;  // -0 below +0
  logic [31:0]                   w_minmax_res;
  logic                          w_cmp_bit;
  logic                          w_cmp_nv;
  logic [fp32_pkg::CLASS_W-1:0]  w_mask;

  fp32_classifier u_cls_rs1 (
    .i_val_i   (i_rs1_i),
    .o_class_o (w_cls1)
  );

  fp32_classifier u_cls_rs2 (
    .i_val_i   (i_rs2_i),
    .o_class_o (w_cls2)
  );

  always_comb begin
    case (i_dec_i.sub_op)
      2'd0:    w_sgn = i_rs2_i.sign;
      2'd1:    w_sgn = ~i_rs2_i.sign;
      default: w_sgn = i_rs1_i.sign ^ i_rs2_i.sign;
    endcase
  end

  assign w_sgnj_res = {w_sgn, i_rs1_i.exp, i_rs1_i.mant};

  assign w_mag_lt    = i_rs1_i[30:0] < i_rs2_i[30:0];
  assign w_bits_eq   = i_rs1_i == i_rs2_i;
  assign w_both_zero = w_cls1.zero & w_cls2.zero;
  assign w_any_nan   = w_cls1.nan | w_cls2.nan;
  assign w_any_snan  = w_cls1.snan | w_cls2.snan;

  always_comb begin
    if (i_rs1_i.sign != i_rs2_i.sign) begin
      w_lt_ord = i_rs1_i.sign;
    end else if (i_rs1_i.sign) begin
      w_lt_ord = ~w_mag_lt & ~w_bits_eq;  // negative, larger magnitude is smaller
    end else begin
      w_lt_ord = w_mag_lt;
    end
  end

  always_comb begin
    if (w_cls1.nan & w_cls2.nan) begin
      w_minmax_res = fp32_pkg::CANONICAL_NAN;
    end else if (w_cls1.nan) begin
      w_minmax_res = i_rs2_i;
    end else if (w_cls2.nan) begin
      w_minmax_res = i_rs1_i;
    end else if (i_dec_i.sub_op[0]) begin
      w_minmax_res = w_lt_ord ? i_rs2_i : i_rs1_i;  // max
    end else begin
      w_minmax_res = w_lt_ord ? i_rs1_i : i_rs2_i;  // min
    end
  end

  always_comb begin
    case (i_dec_i.sub_op)
      2'd0:    w_cmp_bit = w_bits_eq | w_both_zero;
      2'd1:    w_cmp_bit = w_lt_ord & ~w_both_zero;
      default: w_cmp_bit = (w_lt_ord & ~w_both_zero) | w_bits_eq | w_both_zero;
    endcase
    w_cmp_bit = w_cmp_bit & ~w_any_nan;
    w_cmp_nv  = (i_dec_i.sub_op == 2'd0) ? w_any_snan : w_any_nan;  // feq is quiet
  end

  always_comb begin
    w_mask                          = '0;
    w_mask[fp32_pkg::CLS_NEG_INF]   = w_cls1.sign & w_cls1.inf;
    w_mask[fp32_pkg::CLS_NEG_NORM]  = w_cls1.sign & w_cls1.normal;
    w_mask[fp32_pkg::CLS_NEG_SUB]   = w_cls1.sign & w_cls1.subnormal;
    w_mask[fp32_pkg::CLS_NEG_ZERO]  = w_cls1.sign & w_cls1.zero;
    w_mask[fp32_pkg::CLS_POS_ZERO]  = ~w_cls1.sign & w_cls1.zero;
    w_mask[fp32_pkg::CLS_POS_SUB]   = ~w_cls1.sign & w_cls1.subnormal;
    w_mask[fp32_pkg::CLS_POS_NORM]  = ~w_cls1.sign & w_cls1.normal;
    w_mask[fp32_pkg::CLS_POS_INF]   = ~w_cls1.sign & w_cls1.inf;
    w_mask[fp32_pkg::CLS_SNAN]      = w_cls1.snan;
    w_mask[fp32_pkg::CLS_QNAN]      = w_cls1.qnan;
  end

  always_comb begin
    o_resp_o.fflags = '0;
    case (i_dec_i.grp)
      fpu_op_pkg::GRP_SGNJ: o_resp_o.result = w_sgnj_res;
      fpu_op_pkg::GRP_MINMAX: begin
        o_resp_o.result    = w_minmax_res;
        o_resp_o.fflags.nv = w_any_snan;
      end
      fpu_op_pkg::GRP_CMP: begin
        o_resp_o.result    = {31'd0, w_cmp_bit};
        o_resp_o.fflags.nv = w_cmp_nv;
      end
      default: o_resp_o.result = {{(32 - fp32_pkg::CLASS_W){1'b0}}, w_mask};
    endcase
  end

  always_comb begin
    if (i_dec_i.grp == fpu_op_pkg::GRP_CLASS && !$isunknown(i_rs1_i)) begin
      assert final ($onehot(o_resp_o.result[fp32_pkg::CLASS_W-1:0]))
        else $error("fclass mask is not one-hot");
    end
  end

endmodule

//--- rtl/fp32_classifier.sv
`timescale 1ns/1ps

module fp32_classifier (
  input  fp32_pkg::fp32_t        i_val_i,
  output fp32_pkg::fp32_class_t  o_class_o
);

  logic w_exp_ones;
  logic w_exp_zero;
  logic w_mant_zero;

  assign w_exp_ones  = &i_val_i.exp;
  assign w_exp_zero  = ~|i_val_i.exp;
  assign w_mant_zero = ~|i_val_i.mant;

  always_comb begin
    o_class_o.sign      = i_val_i.sign;
    o_class_o.zero      = w_exp_zero & w_mant_zero;
    o_class_o.subnormal = w_exp_zero & ~w_mant_zero;
    o_class_o.normal    = ~w_exp_zero & ~w_exp_ones;
    o_class_o.inf       = w_exp_ones & w_mant_zero;
    o_class_o.nan       = w_exp_ones & ~w_mant_zero;
    o_class_o.snan      = w_exp_ones & ~w_mant_zero & ~i_val_i.mant[22];  // quiet bit clear
    o_class_o.qnan      = w_exp_ones & i_val_i.mant[22];
    o_class_o.spare     = 1'b0;
  end

  // every encoding falls into exactly one category
  always_comb begin
    if (!$isunknown(i_val_i)) begin
      assert final ($onehot({o_class_o.zero, o_class_o.subnormal, o_class_o.normal,
                             o_class_o.inf, o_class_o.nan}))
        else $error("operand class is not one-hot");
    end
  end

endmodule

//--- rtl/fpu_op_decoder.sv
`timescale 1ns/1ps

module fpu_op_decoder (
  input  logic                  i_valid_i,
  input  fpu_op_pkg::fpu_op_e   i_op_i,
  output fpu_op_pkg::fpu_dec_t  o_dec_o,
  output logic                  o_launch_o
);

  fpu_op_pkg::fpu_dec_t w_dec;

  always_comb begin
    w_dec.grp    = fpu_op_pkg::GRP_SGNJ;
    w_dec.sub_op = 2'd0;
    w_dec.legal  = 1'b1;
    case (i_op_i)
      fpu_op_pkg::OP_FSGNJ : w_dec.sub_op = 2'd0;
      fpu_op_pkg::OP_FSGNJN: w_dec.sub_op = 2'd1;
      fpu_op_pkg::OP_FSGNJX: w_dec.sub_op = 2'd2;
      fpu_op_pkg::OP_FMIN: begin
        w_dec.grp    = fpu_op_pkg::GRP_MINMAX;
        w_dec.sub_op = 2'd0;
      end
      fpu_op_pkg::OP_FMAX: begin
        w_dec.grp    = fpu_op_pkg::GRP_MINMAX;
        w_dec.sub_op = 2'd1;
      end
      fpu_op_pkg::OP_FEQ: begin
        w_dec.grp    = fpu_op_pkg::GRP_CMP;
        w_dec.sub_op = 2'd0;
      end
      fpu_op_pkg::OP_FLT: begin
        w_dec.grp    = fpu_op_pkg::GRP_CMP;
        w_dec.sub_op = 2'd1;
      end
      fpu_op_pkg::OP_FLE: begin
        w_dec.grp    = fpu_op_pkg::GRP_CMP;
        w_dec.sub_op = 2'd2;
      end
      fpu_op_pkg::OP_FCLASS: w_dec.grp = fpu_op_pkg::GRP_CLASS;
      default: w_dec.legal = 1'b0;  // 9..15, dropped
    endcase
  end

  assign o_dec_o    = w_dec;
  assign o_launch_o = i_valid_i & w_dec.legal;  // illegal ops never enter the pipe

  always_comb begin
    if (i_valid_i) begin
      assert final (!$isunknown(i_op_i)) else $error("op has unknown bits while valid");
    end
  end

endmodule

//--- rtl/fpu_op_pkg.sv
package fpu_op_pkg;

  // codes 9..15 are not defined and decode as illegal
  typedef enum logic [3:0] {
    OP_FSGNJ  = 4'd0,
    OP_FSGNJN = 4'd1,
    OP_FSGNJX = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FEQ    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FLE    = 4'd7,
    OP_FCLASS = 4'd8
  } fpu_op_e;

  typedef enum logic [1:0] {
    GRP_SGNJ   = 2'd0,
    GRP_MINMAX = 2'd1,
    GRP_CMP    = 2'd2,
    GRP_CLASS  = 2'd3
  } fpu_group_e;

  // sub_op per group
  //   sgnj   : 0 copy, 1 negate, 2 xor
  //   minmax : 0 min, 1 max
  //   cmp    : 0 eq, 1 lt, 2 le
  typedef struct packed {
    fpu_group_e  grp;
    logic [1:0]  sub_op;
    logic        legal;
  } fpu_dec_t;

endpackage

//--- rtl/fp32_pkg.sv
package fp32_pkg;

  parameter int EXP_W   = 8;
  parameter int MANT_W  = 23;
  parameter int CLASS_W = 10;

  parameter logic [31:0] CANONICAL_NAN = 32'h7fc00000;

  // FCLASS mask bit positions
  parameter int CLS_NEG_INF  = 0;
  parameter int CLS_NEG_NORM = 1;
  parameter int CLS_NEG_SUB  = 2;
  parameter int CLS_NEG_ZERO = 3;
  parameter int CLS_POS_ZERO = 4;
  parameter int CLS_POS_SUB  = 5;
  parameter int CLS_POS_NORM = 6;
  parameter int CLS_POS_INF  = 7;
  parameter int CLS_SNAN     = 8;
  parameter int CLS_QNAN     = 9;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [MANT_W-1:0] mant;
  } fp32_t;

  typedef struct packed {
    logic sign;
    logic zero;
    logic subnormal;
    logic normal;
    logic inf;
    logic nan;
    logic snan;
    logic qnan;
    logic spare;  // always 0
  } fp32_class_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic [31:0] result;
    fflags_t     fflags;
  } fpu_resp_t;

endpackage
